//--- common/rename_consts.svh
////////////////////////////////////////////////////////////////////////////
// Size constants for the rename and retire core.
// ROB depth and free-list depth must be powers of two. The pointers wrap
// naturally at the top of their range.
// Free-list depth is the physical count minus the architectural count.
////////////////////////////////////////////////////////////////////////////

`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// Architectural register file size
`define RENAME_ARCH_REGS  32

// Physical register pool, tag 0 stays bound to x0
`define RENAME_PHYS_REGS  64

// Reorder buffer entries
`define RENAME_ROB_DEPTH  16

// Tags not bound to any architectural register at reset
`define RENAME_FREE_DEPTH 32

`endif

//--- common/rename_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared tag and index types for the rename core.
// Widths follow from the size constants. A phys_reg_t of 0 also means
// "no tag allocated" on every rename and commit port.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "rename_consts.svh"

package rename_pkg;

    // Architectural register number, x0 .. x31
    typedef logic [$clog2(`RENAME_ARCH_REGS)-1:0] arch_reg_t;

    // Physical register tag
    typedef logic [$clog2(`RENAME_PHYS_REGS)-1:0] phys_reg_t;

    // ROB slot index
    typedef logic [$clog2(`RENAME_ROB_DEPTH)-1:0] rob_idx_t;

    // ROB occupancy, one bit wider to hold the full count
    typedef logic [$clog2(`RENAME_ROB_DEPTH+1)-1:0] rob_count_t;

    // Free-list read and write pointers
    typedef logic [$clog2(`RENAME_FREE_DEPTH)-1:0] free_ptr_t;

    // Free-list occupancy, 0 .. 32
    typedef logic [$clog2(`RENAME_FREE_DEPTH+1)-1:0] free_count_t;

endpackage

`default_nettype wire

//--- rename/rename_dispatch.sv
////////////////////////////////////////////////////////////////////////////
// Dispatch handshake and allocation decision, one instruction per cycle.
// Ready depends only on ROB and free-list occupancy, never on payload.
// Writes to x0 never allocate.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module rename_dispatch (
    input  wire                   disp_valid_i,
    input  wire                   disp_rd_wen_i,
    input  rename_pkg::arch_reg_t disp_rd_arch_i,
    input  wire                   free_empty_i,
    input  wire                   rob_full_i,
    input  rename_pkg::phys_reg_t free_head_i,
    output logic                  disp_ready_o,
    output logic                  alloc_o,
    output logic                  map_write_o,
    output logic                  rob_write_o,
    output rename_pkg::phys_reg_t disp_new_phys_o
);

    // Instruction wants a fresh physical register
    logic wants_reg;
    // Handshake completes at this edge
    logic fire;

    always_comb begin
        wants_reg = disp_rd_wen_i && (disp_rd_arch_i != '0);

        // Both a ROB slot and a free tag are needed even for non-allocating
        // instructions, keeping ready payload independent
        disp_ready_o = !rob_full_i && !free_empty_i;
        fire         = disp_valid_i && disp_ready_o;

        // Strobes
        rob_write_o = fire;
        alloc_o     = fire && wants_reg;
        map_write_o = fire && wants_reg;

        // Tag 0 marks "nothing allocated" downstream
        disp_new_phys_o = wants_reg ? free_head_i : '0;
    end

endmodule

`default_nettype wire

//--- rename/map_table.sv
////////////////////////////////////////////////////////////////////////////
// Speculative architectural-to-physical map plus physical ready bits.
// Lookups see state from before the current edge; no writeback bypass.
// x0 stays mapped to tag 0, which is always ready.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "rename_consts.svh"

module map_table (
    input  wire                   clock,
    input  wire                   reset,
    input  rename_pkg::arch_reg_t rs1_arch_i,
    input  rename_pkg::arch_reg_t rs2_arch_i,
    input  rename_pkg::arch_reg_t dest_arch_i,
    input  wire                   map_write_i,
    input  rename_pkg::phys_reg_t new_phys_i,
    input  wire                   wb_valid_i,
    input  rename_pkg::phys_reg_t wb_phys_i,
    output rename_pkg::phys_reg_t rs1_phys_o,
    output rename_pkg::phys_reg_t rs2_phys_o,
    output logic                  rs1_ready_o,
    output logic                  rs2_ready_o,
    output rename_pkg::phys_reg_t old_phys_o
);

    // Current mapping per architectural register
    rename_pkg::phys_reg_t map_q [`RENAME_ARCH_REGS];
    // One ready bit per physical tag
    logic [`RENAME_PHYS_REGS-1:0] ready_q;

    ////////////////////////////////////////////////////////////////////////
    // Lookups
    always_comb begin
        rs1_phys_o  = map_q[rs1_arch_i];
        rs2_phys_o  = map_q[rs2_arch_i];
        rs1_ready_o = ready_q[rs1_phys_o];
        rs2_ready_o = ready_q[rs2_phys_o];

        // Previous mapping only when a tag is being handed out
        old_phys_o = (new_phys_i != '0) ? map_q[dest_arch_i] : '0;
    end

    ////////////////////////////////////////////////////////////////////////
    // Map and ready updates
    always_ff @(posedge clock) begin
        if (reset) begin
            // Identity mapping, everything committed and ready
            for (int i = 0; i < `RENAME_ARCH_REGS; i++) begin
                map_q[i] <= rename_pkg::phys_reg_t'(i);
            end
            ready_q <= '1;
        end else begin
            // Completed result
            if (wb_valid_i && (wb_phys_i != '0)) begin
                ready_q[wb_phys_i] <= 1'b1;
            end

            // New destination starts pending
            if (map_write_i) begin
                map_q[dest_arch_i]  <= new_phys_i;
                ready_q[new_phys_i] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- rename/free_list.sv
////////////////////////////////////////////////////////////////////////////
// Circular FIFO of unallocated physical tags, 32 deep.
// Allocation and release may happen at the same edge.
// A release with tag 0 carries nothing and is dropped.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "rename_consts.svh"

module free_list (
    input  wire                   clock,
    input  wire                   reset,
    input  wire                   alloc_i,
    input  wire                   release_i,
    input  rename_pkg::phys_reg_t release_phys_i,
    output rename_pkg::phys_reg_t head_phys_o,
    output logic                  empty_o
);

    rename_pkg::phys_reg_t   fifo_q [`RENAME_FREE_DEPTH];
    rename_pkg::free_ptr_t   rd_ptr_q;
    rename_pkg::free_ptr_t   wr_ptr_q;
    rename_pkg::free_count_t count_q;

    // Effective push and pop this cycle
    logic push;
    logic pop;

    always_comb begin
        head_phys_o = fifo_q[rd_ptr_q];
        empty_o     = (count_q == '0);
        pop         = alloc_i && !empty_o;
        push        = release_i && (release_phys_i != '0);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // Tags above the architectural range start out free
            for (int i = 0; i < `RENAME_FREE_DEPTH; i++) begin
                fifo_q[i] <= rename_pkg::phys_reg_t'(`RENAME_ARCH_REGS + i);
            end
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= rename_pkg::free_count_t'(`RENAME_FREE_DEPTH);
        end else begin
            if (push) begin
                fifo_q[wr_ptr_q] <= release_phys_i;
                wr_ptr_q         <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // Count moves only when one side acts alone
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rob/rob.sv
////////////////////////////////////////////////////////////////////////////
// Circular reorder buffer, 16 entries, retiring one entry per cycle.
// Head retires as soon as it is done, with no back-pressure from outside.
// Writeback must target an occupied entry. Dispatch must not write when full.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "rename_consts.svh"

module rob (
    input  wire                   clock,
    input  wire                   reset,

    // Dispatch side
    input  wire                   rob_write_i,
    input  wire                   rd_wen_i,
    input  rename_pkg::arch_reg_t rd_arch_i,
    input  rename_pkg::phys_reg_t new_phys_i,
    input  rename_pkg::phys_reg_t old_phys_i,

    // Writeback side
    input  wire                   wb_valid_i,
    input  rename_pkg::rob_idx_t  wb_rob_idx_i,

    output logic                  full_o,
    output rename_pkg::rob_idx_t  tail_idx_o,

    // Commit side
    output logic                  commit_valid_o,
    output logic                  commit_rd_wen_o,
    output rename_pkg::arch_reg_t commit_rd_arch_o,
    output rename_pkg::phys_reg_t commit_new_phys_o,
    output rename_pkg::phys_reg_t commit_old_phys_o
);

    ////////////////////////////////////////////////////////////////////////
    // Entry storage
    rename_pkg::arch_reg_t rd_arch_q  [`RENAME_ROB_DEPTH];
    rename_pkg::phys_reg_t new_phys_q [`RENAME_ROB_DEPTH];
    rename_pkg::phys_reg_t old_phys_q [`RENAME_ROB_DEPTH];
    logic [`RENAME_ROB_DEPTH-1:0] rd_wen_q;
    logic [`RENAME_ROB_DEPTH-1:0] done_q;

    // Pointers and occupancy
    rename_pkg::rob_idx_t   head_q;
    rename_pkg::rob_idx_t   tail_q;
    rename_pkg::rob_count_t count_q;

    always_comb begin
        full_o     = (count_q == rename_pkg::rob_count_t'(`RENAME_ROB_DEPTH));
        tail_idx_o = tail_q;

        // Oldest entry leaves once its result is in
        commit_valid_o    = (count_q != '0) && done_q[head_q];
        commit_rd_wen_o   = commit_valid_o && rd_wen_q[head_q];
        commit_rd_arch_o  = rd_arch_q[head_q];
        commit_new_phys_o = new_phys_q[head_q];
        commit_old_phys_o = old_phys_q[head_q];
    end

    ////////////////////////////////////////////////////////////////////////
    // Payload, written at the tail
    always_ff @(posedge clock) begin
        if (rob_write_i) begin
            rd_arch_q[tail_q]  <= rd_arch_i;
            new_phys_q[tail_q] <= new_phys_i;
            old_phys_q[tail_q] <= old_phys_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Control state
    always_ff @(posedge clock) begin
        if (reset) begin
            rd_wen_q <= '0;
            done_q   <= '0;
            head_q   <= '0;
            tail_q   <= '0;
            count_q  <= '0;
        end else begin
            // Result arrived, entry may retire next cycle
            if (wb_valid_i) begin
                done_q[wb_rob_idx_i] <= 1'b1;
            end

            // New entry starts not done
            if (rob_write_i) begin
                rd_wen_q[tail_q] <= rd_wen_i;
                done_q[tail_q]   <= 1'b0;
                tail_q           <= tail_q + 1'b1;
            end

            if (commit_valid_o) begin
                head_q <= head_q + 1'b1;
            end

            // Occupancy
            if (rob_write_i && !commit_valid_o) begin
                count_q <= count_q + 1'b1;
            end else if (commit_valid_o && !rob_write_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/rename_top.sv
////////////////////////////////////////////////////////////////////////////
// Single-wide register rename and in-order retire core.
// The writeback source must only name dispatched, uncommitted ROB entries,
// with the entry's own new tag or 0. No flush or recovery path exists.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module rename_top (
    input  wire                  clock,
    input  wire                  reset,

    // Dispatch
    input  wire                  disp_valid_i,
    input  wire                  disp_rd_wen_i,
    input  rename_pkg::arch_reg_t disp_rd_arch_i,
    input  rename_pkg::arch_reg_t disp_rs1_arch_i,
    input  rename_pkg::arch_reg_t disp_rs2_arch_i,
    output logic                 disp_ready_o,
    output rename_pkg::phys_reg_t disp_rs1_phys_o,
    output logic                 disp_rs1_ready_o,
    output rename_pkg::phys_reg_t disp_rs2_phys_o,
    output logic                 disp_rs2_ready_o,
    output rename_pkg::phys_reg_t disp_new_phys_o,
    output rename_pkg::phys_reg_t disp_old_phys_o,
    output rename_pkg::rob_idx_t disp_rob_idx_o,

    // Writeback
    input  wire                  wb_valid_i,
    input  rename_pkg::rob_idx_t wb_rob_idx_i,
    input  rename_pkg::phys_reg_t wb_phys_i,

    // Commit
    output logic                 commit_valid_o,
    output logic                 commit_rd_wen_o,
    output rename_pkg::arch_reg_t commit_rd_arch_o,
    output rename_pkg::phys_reg_t commit_new_phys_o,
    output rename_pkg::phys_reg_t commit_old_phys_o
);

    // Occupancy flags back to dispatch
    logic                  rob_full;
    logic                  free_empty;
    rename_pkg::phys_reg_t free_head;

    // Write strobes from dispatch
    logic alloc;
    logic map_write;
    logic rob_write;

    ////////////////////////////////////////////////////////////////////////
    // Dispatch control
    rename_dispatch u_dispatch (
        .disp_valid_i    (disp_valid_i),
        .disp_rd_wen_i   (disp_rd_wen_i),
        .disp_rd_arch_i  (disp_rd_arch_i),
        .free_empty_i    (free_empty),
        .rob_full_i      (rob_full),
        .free_head_i     (free_head),
        .disp_ready_o    (disp_ready_o),
        .alloc_o         (alloc),
        .map_write_o     (map_write),
        .rob_write_o     (rob_write),
        .disp_new_phys_o (disp_new_phys_o)
    );

    ////////////////////////////////////////////////////////////////////////
    // Speculative map and ready table
    // New tag arrives already zeroed for non-allocating instructions
    map_table u_map_table (
        .clock       (clock),
        .reset       (reset),
        .rs1_arch_i  (disp_rs1_arch_i),
        .rs2_arch_i  (disp_rs2_arch_i),
        .dest_arch_i (disp_rd_arch_i),
        .map_write_i (map_write),
        .new_phys_i  (disp_new_phys_o),
        .wb_valid_i  (wb_valid_i),
        .wb_phys_i   (wb_phys_i),
        .rs1_phys_o  (disp_rs1_phys_o),
        .rs2_phys_o  (disp_rs2_phys_o),
        .rs1_ready_o (disp_rs1_ready_o),
        .rs2_ready_o (disp_rs2_ready_o),
        .old_phys_o  (disp_old_phys_o)
    );

    ////////////////////////////////////////////////////////////////////////
    // Free list, refilled by commit
    free_list u_free_list (
        .clock          (clock),
        .reset          (reset),
        .alloc_i        (alloc),
        .release_i      (commit_valid_o),
        .release_phys_i (commit_old_phys_o),
        .head_phys_o    (free_head),
        .empty_o        (free_empty)
    );

    ////////////////////////////////////////////////////////////////////////
    // Reorder buffer
    // map_write equals the allocate decision whenever rob_write is high
    rob u_rob (
        .clock             (clock),
        .reset             (reset),
        .rob_write_i       (rob_write),
        .rd_wen_i          (map_write),
        .rd_arch_i         (disp_rd_arch_i),
        .new_phys_i        (disp_new_phys_o),
        .old_phys_i        (disp_old_phys_o),
        .wb_valid_i        (wb_valid_i),
        .wb_rob_idx_i      (wb_rob_idx_i),
        .full_o            (rob_full),
        .tail_idx_o        (disp_rob_idx_o),
        .commit_valid_o    (commit_valid_o),
        .commit_rd_wen_o   (commit_rd_wen_o),
        .commit_rd_arch_o  (commit_rd_arch_o),
        .commit_new_phys_o (commit_new_phys_o),
        .commit_old_phys_o (commit_old_phys_o)
    );

endmodule

`default_nettype wire

//--- dv/rename_tb.sv
////////////////////////////////////////////////////////////////////////////
// Self-checking testbench for the rename and retire core.
// A reference model of map, ready table, free list and ROB is updated at
// every rising edge. Concurrent assertions compare the DUT ports to it.
// Writebacks only target outstanding, not yet done ROB entries.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "rename_consts.svh"

module rename_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] LCG_SEED = 32'h302d_33e4;
    // Identity phase, fill phase without writeback, random phase
    localparam int IDENT_CYCLES  = 32;
    localparam int FILL_CYCLES   = 20;
    localparam int RANDOM_CYCLES = 548;
    localparam int STIM_CYCLES   = IDENT_CYCLES + FILL_CYCLES + RANDOM_CYCLES;
    localparam int CYCLE_LIMIT   = 4 * STIM_CYCLES;

    logic clock;
    logic reset;

    // DUT inputs
    logic disp_valid, disp_rd_wen, wb_valid;
    rename_pkg::arch_reg_t disp_rd_arch, disp_rs1_arch, disp_rs2_arch;
    rename_pkg::rob_idx_t  wb_rob_idx;
    rename_pkg::phys_reg_t wb_phys;

    // DUT outputs
    logic disp_ready, rs1_ready, rs2_ready, commit_valid, commit_rd_wen;
    rename_pkg::phys_reg_t rs1_phys, rs2_phys, new_phys, old_phys;
    rename_pkg::phys_reg_t commit_new_phys, commit_old_phys;
    rename_pkg::rob_idx_t  rob_idx;
    rename_pkg::arch_reg_t commit_rd_arch;

    ////////////////////////////////////////////////////////////////////////
    // Reference model state
    rename_pkg::phys_reg_t map_m [`RENAME_ARCH_REGS];
    logic [`RENAME_PHYS_REGS-1:0] ready_m;
    rename_pkg::phys_reg_t free_m [$];
    logic [`RENAME_ROB_DEPTH-1:0] rob_wen_m, rob_done_m;
    rename_pkg::arch_reg_t rob_rd_m  [`RENAME_ROB_DEPTH];
    rename_pkg::phys_reg_t rob_new_m [`RENAME_ROB_DEPTH];
    rename_pkg::phys_reg_t rob_old_m [`RENAME_ROB_DEPTH];
    rename_pkg::rob_idx_t  rob_head_m, rob_tail_m;
    int rob_count_m;

    // Expected port values, set after each drive
    logic exp_ready, exp_rs1_rdy, exp_rs2_rdy, exp_commit, exp_commit_wen;
    rename_pkg::phys_reg_t exp_rs1, exp_rs2, exp_new, exp_old;
    rename_pkg::phys_reg_t exp_commit_new, exp_commit_old;
    rename_pkg::arch_reg_t exp_commit_rd;
    rename_pkg::rob_idx_t  exp_idx;

    int hs_errors, rename_errors, commit_errors, cycles;
    logic [31:0] lcg_state;
    // Payload refused at the last edge, source must keep it
    logic hold;

    rename_top dut (
        .clock (clock), .reset (reset),
        .disp_valid_i (disp_valid), .disp_rd_wen_i (disp_rd_wen),
        .disp_rd_arch_i (disp_rd_arch), .disp_rs1_arch_i (disp_rs1_arch),
        .disp_rs2_arch_i (disp_rs2_arch), .disp_ready_o (disp_ready),
        .disp_rs1_phys_o (rs1_phys), .disp_rs1_ready_o (rs1_ready),
        .disp_rs2_phys_o (rs2_phys), .disp_rs2_ready_o (rs2_ready),
        .disp_new_phys_o (new_phys), .disp_old_phys_o (old_phys),
        .disp_rob_idx_o (rob_idx),
        .wb_valid_i (wb_valid), .wb_rob_idx_i (wb_rob_idx), .wb_phys_i (wb_phys),
        .commit_valid_o (commit_valid), .commit_rd_wen_o (commit_rd_wen),
        .commit_rd_arch_o (commit_rd_arch), .commit_new_phys_o (commit_new_phys),
        .commit_old_phys_o (commit_old_phys)
    );

    // 40 ns clock
    initial clock = 1'b0;
    always #20 clock = ~clock;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Identity map, all ready, tags 32..63 free, ROB empty
    task automatic reset_model();
        for (int i = 0; i < `RENAME_ARCH_REGS; i++) begin
            map_m[i] = rename_pkg::phys_reg_t'(i);
        end
        ready_m = '1;
        free_m.delete();
        for (int i = 0; i < `RENAME_FREE_DEPTH; i++) begin
            free_m.push_back(rename_pkg::phys_reg_t'(`RENAME_ARCH_REGS + i));
        end
        rob_wen_m = '0;
        rob_done_m = '0;
        rob_head_m = '0;
        rob_tail_m = '0;
        rob_count_m = 0;
        hold = 1'b0;
    endtask

    task automatic compute_expected();
        logic alloc;
        alloc = disp_rd_wen && (disp_rd_arch != '0);
        exp_ready = (rob_count_m < `RENAME_ROB_DEPTH) && (free_m.size() != 0);
        exp_rs1 = map_m[disp_rs1_arch];
        exp_rs2 = map_m[disp_rs2_arch];
        exp_rs1_rdy = ready_m[exp_rs1];
        exp_rs2_rdy = ready_m[exp_rs2];
        exp_new = (alloc && free_m.size() != 0) ? free_m[0] : '0;
        exp_old = alloc ? map_m[disp_rd_arch] : '0;
        exp_idx = rob_tail_m;
        // Head retires once done
        exp_commit = (rob_count_m != 0) && rob_done_m[rob_head_m];
        exp_commit_wen = exp_commit && rob_wen_m[rob_head_m];
        exp_commit_rd = rob_rd_m[rob_head_m];
        exp_commit_new = rob_new_m[rob_head_m];
        exp_commit_old = rob_old_m[rob_head_m];
    endtask

    // Model step at the rising edge, from pre-edge state only
    task automatic update_model();
        logic accept;
        logic retire;
        rename_pkg::phys_reg_t tag;
        accept = disp_valid && exp_ready;
        retire = exp_commit;
        hold = disp_valid && !exp_ready;
        if (wb_valid) begin
            rob_done_m[wb_rob_idx] = 1'b1;
            if (wb_phys != '0) ready_m[wb_phys] = 1'b1;
        end
        if (accept) begin
            if (exp_new != '0) begin
                tag = free_m.pop_front();
                map_m[disp_rd_arch] = tag;
                ready_m[tag] = 1'b0;
            end
            rob_wen_m[rob_tail_m] = (exp_new != '0);
            rob_rd_m[rob_tail_m] = disp_rd_arch;
            rob_new_m[rob_tail_m] = exp_new;
            rob_old_m[rob_tail_m] = exp_old;
            rob_done_m[rob_tail_m] = 1'b0;
            rob_tail_m = rob_tail_m + 1'b1;
            rob_count_m++;
        end
        if (retire) begin
            // Old tag returns to the free-list tail
            if (rob_wen_m[rob_head_m]) free_m.push_back(rob_old_m[rob_head_m]);
            rob_head_m = rob_head_m + 1'b1;
            rob_count_m--;
        end
    endtask

    // Modes: 0 lookups only, 1 allocate without writeback, 2 random, 3 drain
    task automatic drive_inputs(input int mode, input int n);
        logic [31:0] r;
        logic found;
        int k;
        rename_pkg::rob_idx_t idx;
        r = next_random();
        found = 1'b0;
        if (!hold) begin
            disp_valid = (mode == 1) || (mode == 2 && r[1:0] != 2'b00);
            disp_rd_wen = (mode == 1) || (mode == 2 && r[3:2] != 2'b00);
            disp_rd_arch = (mode == 1) ? rename_pkg::arch_reg_t'(1 + n % 31) : r[11:7];
            // Extra weight on x0 destinations
            if (mode == 2 && r[6:4] == 3'b000) disp_rd_arch = '0;
            disp_rs1_arch = (mode == 0) ? rename_pkg::arch_reg_t'(n) : r[16:12];
            disp_rs2_arch = (mode == 0) ? rename_pkg::arch_reg_t'(31 - n) : r[21:17];
        end
        wb_valid = 1'b0;
        wb_rob_idx = '0;
        wb_phys = '0;
        if ((mode == 3 || (mode == 2 && r[23:22] != 2'b00)) && rob_count_m != 0) begin
            k = int'(r[31:24]) % rob_count_m;
            // First outstanding entry from a random offset
            for (int j = 0; j < rob_count_m && !found; j++) begin
                idx = rob_head_m + rename_pkg::rob_idx_t'((k + j) % rob_count_m);
                if (!rob_done_m[idx]) begin
                    found = 1'b1;
                    wb_valid = 1'b1;
                    wb_rob_idx = idx;
                    wb_phys = rob_new_m[idx];
                end
            end
        end
    endtask

    task automatic run_cycle(input int mode, input int n);
        drive_inputs(mode, n);
        compute_expected();
        @(posedge clock);
        update_model();
        @(negedge clock);
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Port checks against the model
    ready_check: assert property (@(posedge clock) disable iff (reset)
        disp_ready == exp_ready)
        else begin
            hs_errors++;
            $display("** Error at %0d ns: disp_ready_o %0b, expected %0b",
                     $time, $sampled(disp_ready), $sampled(exp_ready));
        end

    source_check: assert property (@(posedge clock) disable iff (reset)
        rs1_phys == exp_rs1 && rs1_ready == exp_rs1_rdy &&
        rs2_phys == exp_rs2 && rs2_ready == exp_rs2_rdy)
        else begin
            rename_errors++;
            $display("** Error at %0d ns: sources %0d/%0b %0d/%0b, expected %0d/%0b %0d/%0b",
                     $time, $sampled(rs1_phys), $sampled(rs1_ready), $sampled(rs2_phys),
                     $sampled(rs2_ready), $sampled(exp_rs1), $sampled(exp_rs1_rdy),
                     $sampled(exp_rs2), $sampled(exp_rs2_rdy));
        end

    alloc_check: assert property (@(posedge clock) disable iff (reset)
        (disp_valid && exp_ready) |->
            (new_phys == exp_new && old_phys == exp_old && rob_idx == exp_idx))
        else begin
            rename_errors++;
            $display("** Error at %0d ns: new/old/idx %0d/%0d/%0d, expected %0d/%0d/%0d",
                     $time, $sampled(new_phys), $sampled(old_phys), $sampled(rob_idx),
                     $sampled(exp_new), $sampled(exp_old), $sampled(exp_idx));
        end

    commit_check: assert property (@(posedge clock) disable iff (reset)
        commit_valid == exp_commit && (!exp_commit ||
            (commit_rd_wen == exp_commit_wen && commit_rd_arch == exp_commit_rd &&
             commit_new_phys == exp_commit_new && commit_old_phys == exp_commit_old)))
        else begin
            commit_errors++;
            $display("** Error at %0d ns: commit %0b wen %0b rd %0d new %0d old %0d, ",
                     $time, $sampled(commit_valid), $sampled(commit_rd_wen),
                     $sampled(commit_rd_arch), $sampled(commit_new_phys),
                     $sampled(commit_old_phys),
                     "expected %0b %0b %0d %0d %0d",
                     $sampled(exp_commit), $sampled(exp_commit_wen),
                     $sampled(exp_commit_rd), $sampled(exp_commit_new), $sampled(exp_commit_old));
        end

    // Watchdog
    always @(posedge clock) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Stimulus
    initial begin
        hs_errors = 0;
        rename_errors = 0;
        commit_errors = 0;
        cycles = 0;
        lcg_state = LCG_SEED;
        reset = 1'b1;
        disp_valid = 1'b0;
        disp_rd_wen = 1'b0;
        disp_rd_arch = '0;
        disp_rs1_arch = '0;
        disp_rs2_arch = '0;
        wb_valid = 1'b0;
        wb_rob_idx = '0;
        wb_phys = '0;
        reset_model();
        compute_expected();
        repeat (16) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        for (int i = 0; i < IDENT_CYCLES; i++) run_cycle(0, i);
        // ROB fills after 16, last payloads wait
        for (int i = 0; i < FILL_CYCLES; i++) run_cycle(1, i);
        for (int i = 0; i < RANDOM_CYCLES; i++) run_cycle(2, i);
        while (rob_count_m != 0 || hold) run_cycle(3, 0);
        repeat (4) run_cycle(3, 0);

        $display("Error counts: handshake %0d, rename %0d, commit %0d",
                 hs_errors, rename_errors, commit_errors);
        if (hs_errors + rename_errors + commit_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+common
common/rename_pkg.sv
rename/rename_dispatch.sv
rename/map_table.sv
rename/free_list.sv
rob/rob.sv
hdl/rename_top.sv
dv/rename_tb.sv

//--- Bender.yml
package:
  name: rename_core

export_include_dirs:
  - common

sources:
  - files:
      - common/rename_pkg.sv
      - rename/rename_dispatch.sv
      - rename/map_table.sv
      - rename/free_list.sv
      - rob/rob.sv
      - hdl/rename_top.sv
  - target: simulation
    files:
      - dv/rename_tb.sv
